//--- verilog/cpu24_pkg.sv
package cpu24_pkg;

  typedef logic [31:0] word_t;   // Data word
  typedef logic [23:0] addr_t;   // Word address, code and data alike
  typedef logic [23:0] instr_t;
  typedef logic [3:0]  reg_id_t;

  // Opcode field, bits 23..19
  typedef enum logic [4:0] {
    ADD   = 5'h00,
    SUB   = 5'h01,
    AND   = 5'h02,
    OR    = 5'h03,
    XOR   = 5'h04,
    LSL   = 5'h05,
    LSR   = 5'h06,
    LD_W  = 5'h08,
    STO_W = 5'h09,   // Data register in the rdst field
    JMP   = 5'h10,
    JSR   = 5'h11,
    JRCC  = 5'h12,
    RET   = 5'h13,
    NOP   = 5'h1f    // Decoded form of every unused encoding
  } op_e;

  // Jump conditions; code 15 is spare and behaves as AL
  typedef enum logic [3:0] {
    AL = 4'h0,
    EQ = 4'h1,
    NE = 4'h2,
    CS = 4'h3,
    CC = 4'h4,
    MI = 4'h5,
    PL = 4'h6,
    VS = 4'h7,
    VC = 4'h8,
    HI = 4'h9,
    LS = 4'ha,
    GE = 4'hb,
    LT = 4'hc,
    GT = 4'hd,
    LE = 4'he
  } cond_e;

  localparam int OP_MSB      = 23;
  localparam int OP_LSB      = 19;
  localparam int IMM_SEL_BIT = 18;   // Register-immediate form of ALU ops
  localparam int RDST_MSB    = 17;   // Holds the condition for JRCC
  localparam int RDST_LSB    = 14;
  localparam int RSRC0_MSB   = 13;
  localparam int RSRC0_LSB   = 10;
  localparam int RSRC1_MSB   = 9;
  localparam int RSRC1_LSB   = 6;
  localparam int IMM10_MSB   = 9;    // Short immediate 9..0, sign extended
  localparam int IMM14_MSB   = 13;   // Absolute target 13..0, zero extended

  localparam reg_id_t LINK_REG = 4'd13;
  localparam reg_id_t ZERO_REG = 4'd0;
  localparam addr_t   RESET_PC = 24'd0;

  typedef struct packed {
    logic z;
    logic s;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    op_e     op;
    logic    use_imm;
    reg_id_t rdst;
    logic    rd_we;
    reg_id_t rsrc0;
    reg_id_t rsrc1;
    cond_e   cond;
    word_t   imm;
  } dec_t;

  typedef struct packed {
    dec_t  dec;
    word_t opnd0;
    word_t opnd1;
    addr_t pc;
    logic  valid;
  } ex_t;

  typedef struct packed {
    logic  rd;
    logic  wr;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic    we;
    reg_id_t addr;
    word_t   data;
  } wb_t;

endpackage

//--- verilog/cpu24_alu.sv
`timescale 1ns/1ps

module cpu24_alu (
  input  cpu24_pkg::op_e    i_op,
  input  cpu24_pkg::word_t  i_a,
  input  cpu24_pkg::word_t  i_b,
  output cpu24_pkg::word_t  o_result,
  output cpu24_pkg::flags_t o_flags
);
  import cpu24_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;
  logic [4:0]  shamt;
  word_t       result;
  flags_t      flags;

  assign sum   = {1'b0, i_a} + {1'b0, i_b};
  assign diff  = {1'b0, i_a} + {1'b0, ~i_b} + 33'd1;   // Carry out set means no borrow
  assign shamt = i_b[4:0];

  always_comb begin
    flags = '0;   // Logic and shift ops leave c and v clear
    case (i_op)
      SUB: begin
        result  = diff[31:0];
        flags.c = diff[32];
        flags.v = (i_a[31] != i_b[31]) && (diff[31] != i_a[31]);
      end
      AND: result = i_a & i_b;
      OR:  result = i_a | i_b;
      XOR: result = i_a ^ i_b;
      LSL: result = i_a << shamt;
      LSR: result = i_a >> shamt;
      default: begin
        // ADD, and the target sum for everything that is not an ALU op
        result  = sum[31:0];
        flags.c = sum[32];
        flags.v = (i_a[31] == i_b[31]) && (sum[31] != i_a[31]);
      end
    endcase
    flags.z = (result == '0);
    flags.s = result[31];
  end

  assign o_result = result;
  assign o_flags  = flags;

endmodule

//--- verilog/cpu24_decode.sv
`timescale 1ns/1ps

module cpu24_decode (
  input  cpu24_pkg::instr_t i_instr,
  output cpu24_pkg::dec_t   o_dec
);
  import cpu24_pkg::*;

  op_e     raw_op;
  reg_id_t f_rdst;
  reg_id_t f_rsrc0;
  reg_id_t f_rsrc1;
  word_t   imm10_sext;
  word_t   imm14_zext;

  assign raw_op     = op_e'(i_instr[OP_MSB:OP_LSB]);
  assign f_rdst     = i_instr[RDST_MSB:RDST_LSB];
  assign f_rsrc0    = i_instr[RSRC0_MSB:RSRC0_LSB];
  assign f_rsrc1    = i_instr[RSRC1_MSB:RSRC1_LSB];
  assign imm10_sext = {{(31 - IMM10_MSB){i_instr[IMM10_MSB]}}, i_instr[IMM10_MSB:0]};
  assign imm14_zext = {{(31 - IMM14_MSB){1'b0}}, i_instr[IMM14_MSB:0]};

  // Unused register fields are parked on R0 so the hazard check never sees them
  always_comb begin
    o_dec         = '0;
    o_dec.op      = NOP;
    o_dec.cond    = AL;
    o_dec.imm     = imm10_sext;
    o_dec.rdst    = ZERO_REG;
    o_dec.rsrc0   = ZERO_REG;
    o_dec.rsrc1   = ZERO_REG;
    case (raw_op)
      ADD, SUB, AND, OR, XOR, LSL, LSR: begin
        o_dec.op      = raw_op;
        o_dec.use_imm = i_instr[IMM_SEL_BIT];
        o_dec.rdst    = f_rdst;
        o_dec.rsrc0   = f_rsrc0;
        if (!i_instr[IMM_SEL_BIT])
          o_dec.rsrc1 = f_rsrc1;   // Immediate overlays the rsrc1 bits
      end
      LD_W: begin
        o_dec.op      = LD_W;
        o_dec.use_imm = 1'b1;
        o_dec.rdst    = f_rdst;
        o_dec.rsrc0   = f_rsrc0;   // Base register
      end
      STO_W: begin
        o_dec.op      = STO_W;
        o_dec.use_imm = 1'b1;
        o_dec.rsrc0   = f_rsrc0;
        o_dec.rsrc1   = f_rdst;    // Store data comes from the rdst field
      end
      JMP, JSR: begin
        o_dec.op      = raw_op;
        o_dec.use_imm = 1'b1;
        o_dec.imm     = imm14_zext;
        if (raw_op == JSR)
          o_dec.rdst  = LINK_REG;
      end
      JRCC: begin
        o_dec.op      = JRCC;
        o_dec.use_imm = 1'b1;
        o_dec.cond    = cond_e'(f_rdst);
      end
      RET: begin
        o_dec.op      = RET;
        o_dec.rsrc0   = LINK_REG;  // Jump through the link register
      end
      default: ;
    endcase
    // Classes without a result keep rdst at R0, so this covers them too
    o_dec.rd_we = (o_dec.rdst != ZERO_REG);
  end

endmodule

//--- verilog/cpu24_regfile.sv
`timescale 1ns/1ps

module cpu24_regfile (
  input  logic               i_clk,
  input  cpu24_pkg::wb_t     i_wb,
  input  cpu24_pkg::reg_id_t i_raddr0,
  input  cpu24_pkg::reg_id_t i_raddr1,
  output cpu24_pkg::word_t   o_rdata0,
  output cpu24_pkg::word_t   o_rdata1
);
  import cpu24_pkg::*;

  word_t regs [16];

  // R0 reads zero, a same-cycle write is forwarded
  function automatic word_t rd_mux(reg_id_t raddr, word_t stored, wb_t wb);
    if (raddr == ZERO_REG)
      return '0;
    if (wb.we && (wb.addr == raddr))
      return wb.data;
    return stored;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_wb.we && (i_wb.addr != ZERO_REG))
      regs[i_wb.addr] <= i_wb.data;
  end

  assign o_rdata0 = rd_mux(i_raddr0, regs[i_raddr0], i_wb);
  assign o_rdata1 = rd_mux(i_raddr1, regs[i_raddr1], i_wb);

  // Decode must already have dropped the write enable for R0
  a_no_r0_write: assert property (@(posedge i_clk) !(i_wb.we && (i_wb.addr == ZERO_REG)));

endmodule

//--- verilog/cpu24_execute.sv
`timescale 1ns/1ps

module cpu24_execute (
  input  logic                i_clk,
  input  logic                i_rstb,
  input  cpu24_pkg::ex_t      i_ex,
  input  cpu24_pkg::word_t    i_din,
  output cpu24_pkg::mem_req_t o_mem,
  output cpu24_pkg::wb_t      o_wb,
  output logic                o_redirect,
  output cpu24_pkg::addr_t    o_target
);
  import cpu24_pkg::*;

  ex_t    ex_q;
  flags_t psr_q;
  flags_t psr_d;
  word_t  ea;
  word_t  alu_a;
  word_t  alu_b;
  word_t  alu_result;
  flags_t alu_flags;
  addr_t  link_pc;
  logic   cond_ok;

  // Memory request leaves one cycle ahead of execute, so the load data is back in time
  assign ea = i_ex.opnd0 + i_ex.dec.imm;

  always_comb begin
    o_mem.rd    = i_ex.valid && (i_ex.dec.op == LD_W);
    o_mem.wr    = i_ex.valid && (i_ex.dec.op == STO_W);
    o_mem.addr  = ea[23:0];
    o_mem.wdata = i_ex.opnd1;
  end

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      ex_q.valid <= 1'b0;
      psr_q      <= '0;
    end else begin
      ex_q <= i_ex;
      if (ex_q.valid)
        psr_q <= psr_d;
    end
  end

  assign alu_a = (ex_q.dec.op == JRCC) ? word_t'(ex_q.pc) : ex_q.opnd0;   // PC-relative
  assign alu_b = ex_q.dec.use_imm ? ex_q.dec.imm : ex_q.opnd1;

  cpu24_alu u_alu (
    .i_op     (ex_q.dec.op),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_result),
    .o_flags  (alu_flags)
  );

  assign link_pc = ex_q.pc + 24'd1;

  always_comb begin
    o_wb.we   = ex_q.valid && ex_q.dec.rd_we;
    o_wb.addr = ex_q.dec.rdst;
    o_wb.data = alu_result;
    psr_d     = psr_q;   // Stores and jumps keep the flags
    case (ex_q.dec.op)
      ADD, SUB, AND, OR, XOR, LSL, LSR: psr_d = alu_flags;
      LD_W: begin
        o_wb.data = i_din;
        psr_d.z   = (i_din == '0);
        psr_d.s   = i_din[31];
      end
      JSR: o_wb.data = word_t'(link_pc);
      default: ;
    endcase
  end

  always_comb begin
    case (ex_q.dec.cond)
      EQ: cond_ok = psr_q.z;
      NE: cond_ok = !psr_q.z;
      CS: cond_ok = psr_q.c;
      CC: cond_ok = !psr_q.c;
      MI: cond_ok = psr_q.s;
      PL: cond_ok = !psr_q.s;
      VS: cond_ok = psr_q.v;
      VC: cond_ok = !psr_q.v;
      HI: cond_ok = psr_q.c && !psr_q.z;
      LS: cond_ok = !psr_q.c || psr_q.z;
      GE: cond_ok = (psr_q.s == psr_q.v);
      LT: cond_ok = (psr_q.s != psr_q.v);
      GT: cond_ok = !psr_q.z && (psr_q.s == psr_q.v);
      LE: cond_ok = psr_q.z || (psr_q.s != psr_q.v);
      default: cond_ok = 1'b1;   // AL and the spare code
    endcase
  end

  always_comb begin
    o_redirect = 1'b0;
    o_target   = ex_q.dec.imm[23:0];   // Absolute target of JMP and JSR
    if (ex_q.valid) begin
      case (ex_q.dec.op)
        JMP, JSR: o_redirect = 1'b1;
        RET: begin
          o_redirect = 1'b1;
          o_target   = ex_q.opnd0[23:0];
        end
        JRCC: begin
          o_redirect = cond_ok;
          o_target   = alu_result[23:0];
        end
        default: ;
      endcase
    end
  end

  a_mem_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_rstb)
    !(o_mem.rd && o_mem.wr));

  // A redirect comes from a valid stage, and the core flushes what follows it
  a_redirect_flush: assert property (@(posedge i_clk) disable iff (!i_rstb)
    o_redirect |-> ex_q.valid ##1 !ex_q.valid);

endmodule

//--- verilog/cpu24_core.sv
`timescale 1ns/1ps

module cpu24_core (
  input  logic                i_clk,
  input  logic                i_rstb,
  input  cpu24_pkg::instr_t   i_instr,
  input  cpu24_pkg::word_t    i_din,
  output cpu24_pkg::addr_t    o_iaddr,
  output cpu24_pkg::mem_req_t o_mem
);
  import cpu24_pkg::*;

  addr_t pc_q;
  addr_t pc_d;
  dec_t  dec;
  dec_t  iss_dec_q;   // Issue-stage register
  addr_t iss_pc_q;
  logic  iss_valid_q;
  logic  iss_valid_d;
  logic  stall;
  logic  redirect;
  addr_t target;
  word_t rdata0;
  word_t rdata1;
  wb_t   wb;
  ex_t   ex;

  assign o_iaddr = pc_q;   // Instruction memory answers in the same cycle

  cpu24_decode u_decode (
    .i_instr (i_instr),
    .o_dec   (dec)
  );

  // Back-to-back dependency on the instruction now in issue
  // R0 never matches because rd_we is clear for it
  assign stall = iss_valid_q && iss_dec_q.rd_we &&
                 ((dec.rsrc0 == iss_dec_q.rdst) || (dec.rsrc1 == iss_dec_q.rdst));

  always_comb begin
    if (redirect)
      pc_d = target;        // Taken jump wins over a stall
    else if (stall)
      pc_d = pc_q;
    else
      pc_d = pc_q + 24'd1;
  end

  assign iss_valid_d = !redirect && !stall;   // Bubble on stall or flush

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      pc_q        <= RESET_PC;
      iss_valid_q <= 1'b0;
    end else begin
      pc_q        <= pc_d;
      iss_valid_q <= iss_valid_d;
    end
  end

  always_ff @(posedge i_clk) begin
    iss_dec_q <= dec;
    iss_pc_q  <= pc_q;
  end

  cpu24_regfile u_regfile (
    .i_clk    (i_clk),
    .i_wb     (wb),
    .i_raddr0 (iss_dec_q.rsrc0),
    .i_raddr1 (iss_dec_q.rsrc1),
    .o_rdata0 (rdata0),
    .o_rdata1 (rdata1)
  );

  always_comb begin
    ex.dec   = iss_dec_q;
    ex.opnd0 = rdata0;
    ex.opnd1 = rdata1;
    ex.pc    = iss_pc_q;
    ex.valid = iss_valid_q && !redirect;   // Discard the slot behind a taken jump
  end

  cpu24_execute u_execute (
    .i_clk      (i_clk),
    .i_rstb     (i_rstb),
    .i_ex       (ex),
    .i_din      (i_din),
    .o_mem      (o_mem),
    .o_wb       (wb),
    .o_redirect (redirect),
    .o_target   (target)
  );

  // The bubble behind a stall carries no destination, so a second stall cannot follow
  a_stall_once: assert property (@(posedge i_clk) disable iff (!i_rstb) stall |=> !stall);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk,
  output logic o_rstb
);
  initial o_clk  = 1'b0;
  initial o_rstb = 1'b0;

  always #4 o_clk = ~o_clk;   // 8 ns period

  task automatic hold_reset();
    @(negedge o_clk);
    o_rstb <= 1'b0;
  endtask

  // Reset stays low for three cycles in total
  task automatic release_reset();
    repeat (3) @(negedge o_clk);
    o_rstb <= 1'b1;
  endtask

endmodule

//--- tests/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input logic                i_clk,
  input logic                i_rstb,
  input cpu24_pkg::addr_t    i_iaddr,
  input cpu24_pkg::mem_req_t i_mem
);
  import cpu24_pkg::*;

  addr_t exp_addr [10];
  word_t exp_data [10];
  int    n_exp    = 0;
  int    n_seen   = 0;
  int    n_err    = 0;
  int    rst_err  = 0;   // Errors seen right after reset release
  int    err_mark = 0;

  always @(negedge i_clk) begin
    if (!i_rstb) begin
      n_seen <= 0;
      if (i_mem.rd || i_mem.wr || (i_iaddr != RESET_PC)) begin
        $display("reset state wrong during reset: rd=%b wr=%b iaddr=%h",
                 i_mem.rd, i_mem.wr, i_iaddr);
        n_err <= n_err + 1;
      end
    end else if (i_mem.wr) begin
      if (n_seen >= n_exp) begin
        $display("unexpected extra store of %h to address %h", i_mem.wdata, i_mem.addr);
        n_err <= n_err + 1;
      end else if (i_mem.addr != exp_addr[n_seen]) begin
        $display("CHECK FAILED o_mem.addr expected %h got %h", exp_addr[n_seen], i_mem.addr);
        n_err <= n_err + 1;
      end else if (i_mem.wdata != exp_data[n_seen]) begin
        $display("CHECK FAILED o_mem.wdata expected %h got %h", exp_data[n_seen], i_mem.wdata);
        n_err <= n_err + 1;
      end
      n_seen <= n_seen + 1;
    end
  end

  // First cycle after reset goes high, before the next rising edge
  always @(posedge i_rstb) begin
    #1;
    if (i_mem.rd || i_mem.wr || (i_iaddr != RESET_PC)) begin
      $display("reset state wrong after release: rd=%b wr=%b iaddr=%h",
               i_mem.rd, i_mem.wr, i_iaddr);
      rst_err = rst_err + 1;
    end
  end

  task automatic clear_expect();
    n_exp = 0;
  endtask

  task automatic add_expect(input addr_t a, input word_t d);
    exp_addr[n_exp] = a;
    exp_data[n_exp] = d;
    n_exp = n_exp + 1;
  endtask

  task automatic report(input string name, output logic ok);
    int errs;
    errs = n_err + rst_err - err_mark;
    if (n_seen < n_exp) begin
      $display("test %s is missing %0d of %0d expected stores", name, n_exp - n_seen, n_exp);
      errs = errs + 1;
    end
    err_mark = n_err + rst_err;
    ok = (errs == 0);
    $display("%-10s %0d/%0d stores, %0d errors, %s", name, n_seen, n_exp, errs,
             ok ? "ok" : "failed");
  endtask

endmodule

//--- tests/tb_cpu24.sv
`timescale 1ns/1ps

module tb_cpu24;
  import cpu24_pkg::*;

  localparam int N_TESTS       = 7;
  localparam int PROG_LEN      = 16;
  localparam int MAX_ST        = 10;
  localparam int STORE_TIMEOUT = 300;   // Cycles

  logic     clk;
  logic     rstb;
  instr_t   instr = '0;
  word_t    din   = '0;
  addr_t    iaddr;
  mem_req_t mem;

  instr_t     imem [PROG_LEN];
  word_t      dmem [256];
  logic       rd_pend = 1'b0;
  logic [7:0] rd_addr = '0;

  // Test table
  instr_t prog_tab [N_TESTS][PROG_LEN];
  string  name_tab [N_TESTS];
  int     n_exp_tab [N_TESTS];
  addr_t  exp_addr_tab [N_TESTS][MAX_ST];
  word_t  exp_data_tab [N_TESTS][MAX_ST];
  int     cur_t;
  int     cur_pc;

  logic [31:0] rnd_state = 32'd23;
  int          n_pass = 0;
  int          n_fail = 0;

  tb_clock u_clk (
    .o_clk  (clk),
    .o_rstb (rstb)
  );

  cpu24_core i_dut (
    .i_clk   (clk),
    .i_rstb  (rstb),
    .i_instr (instr),
    .i_din   (din),
    .o_iaddr (iaddr),
    .o_mem   (mem)
  );

  tb_checker u_chk (
    .i_clk   (clk),
    .i_rstb  (rstb),
    .i_iaddr (iaddr),
    .i_mem   (mem)
  );

  // Instruction and data memory models
  always @(negedge clk) begin
    instr <= (iaddr < addr_t'(PROG_LEN)) ? imem[iaddr[3:0]] : '0;
    din   <= rd_pend ? dmem[rd_addr] : '0;   // Read data from last cycle's request
    if (!rstb) begin
      for (int i = 0; i < 256; i++)
        dmem[i] = '0;
    end else if (mem.wr) begin
      dmem[mem.addr[7:0]] = mem.wdata;
    end
    rd_pend <= mem.rd;
    rd_addr <= mem.addr[7:0];
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t sext10(input logic [9:0] v);
    return {{22{v[9]}}, v};
  endfunction

  function automatic instr_t enc(input op_e op, input logic isel, input reg_id_t rd,
                                 input reg_id_t rs0, input logic [9:0] low);
    return {op, isel, rd, rs0, low};
  endfunction

  function automatic instr_t rr(input op_e op, input reg_id_t rd, input reg_id_t ra,
                                input reg_id_t rb);
    return enc(op, 1'b0, rd, ra, {rb, 6'b0});
  endfunction

  function automatic instr_t ri(input op_e op, input reg_id_t rd, input reg_id_t ra,
                                input logic [9:0] imm);
    return enc(op, 1'b1, rd, ra, imm);
  endfunction

  function automatic instr_t jump(input op_e op, input logic [13:0] target);
    return enc(op, 1'b0, 4'd0, target[13:10], target[9:0]);
  endfunction

  // Flags of a - b by the SUB rules, then the condition table
  function automatic logic cond_true(input cond_e c, input word_t a, input word_t b);
    word_t  d;
    longint sd;
    logic   z;
    logic   s;
    logic   cy;
    logic   v;
    d  = a - b;
    sd = longint'($signed(a)) - longint'($signed(b));   // Exact signed difference
    z  = (d == '0);
    s  = d[31];
    cy = (a >= b);
    v  = (sd != longint'($signed(d)));
    case (c)
      EQ: return z;
      NE: return !z;
      CS: return cy;
      CC: return !cy;
      MI: return s;
      PL: return !s;
      VS: return v;
      VC: return !v;
      HI: return cy && !z;
      LS: return !cy || z;
      GE: return s == v;
      LT: return s != v;
      GT: return !z && (s == v);
      LE: return z || (s != v);
      default: return 1'b1;
    endcase
  endfunction

  task automatic draw10(output logic [9:0] v);
    rnd_state = xorshift(rnd_state);
    v = rnd_state[9:0];
  endtask

  task automatic open_test(input int t, input string name);
    cur_t  = t;
    cur_pc = 0;
    name_tab[t]  = name;
    n_exp_tab[t] = 0;
    for (int i = 0; i < PROG_LEN; i++)
      prog_tab[t][i] = '0;
  endtask

  task automatic emit(input instr_t i);
    prog_tab[cur_t][cur_pc] = i;
    cur_pc = cur_pc + 1;
  endtask

  task automatic expect_store(input logic [9:0] a, input word_t d);
    exp_addr_tab[cur_t][n_exp_tab[cur_t]] = {14'b0, a};
    exp_data_tab[cur_t][n_exp_tab[cur_t]] = d;
    n_exp_tab[cur_t] = n_exp_tab[cur_t] + 1;
  endtask

  task automatic loop_here();
    emit(jump(JMP, 14'(cur_pc)));
  endtask

  // JRCC over two stores; r1, r2 and r3 = r1 - r2 are already set
  task automatic jrcc_block(input cond_e c, input logic [9:0] base, input word_t a,
                            input word_t b);
    emit(enc(JRCC, 1'b0, reg_id_t'(c), 4'd0, 10'd3));
    emit(enc(STO_W, 1'b0, 4'd1, 4'd0, base));
    emit(enc(STO_W, 1'b0, 4'd2, 4'd0, base + 10'd1));
    emit(enc(STO_W, 1'b0, 4'd3, 4'd0, base + 10'd2));
    if (!cond_true(c, a, b)) begin
      expect_store(base, a);
      expect_store(base + 10'd1, b);
    end
    expect_store(base + 10'd2, a - b);
  endtask

  task automatic build_table();
    logic [9:0] a10;
    logic [9:0] b10;
    logic [9:0] n10;
    logic [4:0] sh;
    word_t      a;
    word_t      b;
    word_t      n;

    open_test(0, "alu_rr");
    draw10(a10);
    draw10(b10);
    a = sext10(a10);
    b = sext10(b10);
    emit(ri(ADD, 4'd1, 4'd0, a10));
    emit(ri(ADD, 4'd2, 4'd0, b10));
    emit(rr(ADD, 4'd3, 4'd1, 4'd2));
    emit(enc(STO_W, 1'b0, 4'd3, 4'd0, 10'h10));
    expect_store(10'h10, a + b);
    emit(rr(SUB, 4'd4, 4'd1, 4'd2));
    emit(enc(STO_W, 1'b0, 4'd4, 4'd0, 10'h11));
    expect_store(10'h11, a - b);
    emit(rr(AND, 4'd5, 4'd1, 4'd2));
    emit(enc(STO_W, 1'b0, 4'd5, 4'd0, 10'h12));
    expect_store(10'h12, a & b);
    emit(rr(OR, 4'd6, 4'd1, 4'd2));
    emit(enc(STO_W, 1'b0, 4'd6, 4'd0, 10'h13));
    expect_store(10'h13, a | b);
    emit(rr(XOR, 4'd7, 4'd1, 4'd2));
    emit(enc(STO_W, 1'b0, 4'd7, 4'd0, 10'h14));
    expect_store(10'h14, a ^ b);
    loop_here();

    open_test(1, "alu_imm");
    draw10(a10);
    draw10(b10);
    draw10(n10);
    sh  = b10[4:0];
    n10 = n10 | 10'h200;   // Negative immediate
    a   = sext10(a10);
    n   = sext10(n10);
    emit(ri(ADD, 4'd1, 4'd0, a10));
    emit(ri(LSL, 4'd2, 4'd1, {5'b0, sh}));
    emit(enc(STO_W, 1'b0, 4'd2, 4'd0, 10'h18));
    expect_store(10'h18, a << sh);
    emit(ri(LSR, 4'd3, 4'd1, {5'b0, sh}));
    emit(enc(STO_W, 1'b0, 4'd3, 4'd0, 10'h19));
    expect_store(10'h19, a >> sh);
    emit(ri(ADD, 4'd4, 4'd1, n10));
    emit(enc(STO_W, 1'b0, 4'd4, 4'd0, 10'h1a));
    expect_store(10'h1a, a + n);
    emit(ri(SUB, 4'd5, 4'd1, n10));
    emit(enc(STO_W, 1'b0, 4'd5, 4'd0, 10'h1b));
    expect_store(10'h1b, a - n);
    emit(ri(XOR, 4'd6, 4'd1, n10));
    emit(enc(STO_W, 1'b0, 4'd6, 4'd0, 10'h1c));
    expect_store(10'h1c, a ^ n);
    loop_here();

    // Each instruction reads the one before it
    open_test(2, "chain");
    emit(ri(ADD, 4'd1, 4'd0, 10'd5));
    emit(rr(ADD, 4'd1, 4'd1, 4'd1));
    emit(ri(SUB, 4'd2, 4'd1, 10'd3));
    emit(enc(STO_W, 1'b0, 4'd2, 4'd0, 10'h20));
    expect_store(10'h20, 32'd7);
    emit(enc(LD_W, 1'b0, 4'd3, 4'd0, 10'h20));
    emit(rr(ADD, 4'd4, 4'd3, 4'd3));   // Load then use
    emit(enc(STO_W, 1'b0, 4'd4, 4'd0, 10'h21));
    expect_store(10'h21, 32'd14);
    loop_here();

    open_test(3, "ld_st");
    emit(ri(ADD, 4'd1, 4'd0, 10'h3b3));
    emit(enc(STO_W, 1'b0, 4'd1, 4'd0, 10'h30));
    expect_store(10'h30, sext10(10'h3b3));
    emit(enc(LD_W, 1'b0, 4'd2, 4'd0, 10'h30));
    emit(enc(STO_W, 1'b0, 4'd2, 4'd0, 10'h31));
    expect_store(10'h31, sext10(10'h3b3));
    emit(enc(LD_W, 1'b0, 4'd3, 4'd0, 10'h35));   // Never written
    emit(enc(STO_W, 1'b0, 4'd3, 4'd0, 10'h32));
    expect_store(10'h32, 32'd0);
    loop_here();

    open_test(4, "jrcc_rnd");
    draw10(a10);
    draw10(b10);
    a = sext10(a10);
    b = sext10(b10);
    emit(ri(ADD, 4'd1, 4'd0, a10));
    emit(ri(ADD, 4'd2, 4'd0, b10));
    emit(rr(SUB, 4'd3, 4'd1, 4'd2));
    jrcc_block(NE, 10'h40, a, b);
    jrcc_block(GE, 10'h43, a, b);
    jrcc_block(LS, 10'h46, a, b);
    loop_here();

    open_test(5, "jrcc_eq");
    draw10(a10);
    a = sext10(a10);
    emit(ri(ADD, 4'd1, 4'd0, a10));
    emit(ri(ADD, 4'd2, 4'd0, a10));
    emit(rr(SUB, 4'd3, 4'd1, 4'd2));
    jrcc_block(EQ, 10'h50, a, a);
    jrcc_block(HI, 10'h53, a, a);
    jrcc_block(LE, 10'h56, a, a);
    loop_here();

    // Subroutine at 6 stores the link value, then returns to 2
    open_test(6, "jsr_ret");
    emit(ri(ADD, 4'd1, 4'd0, 10'd9));
    emit(jump(JSR, 14'd6));
    emit(enc(STO_W, 1'b0, 4'd1, 4'd0, 10'h60));
    loop_here();
    cur_pc = 6;
    emit(enc(STO_W, 1'b0, LINK_REG, 4'd0, 10'h61));
    emit(enc(RET, 1'b0, 4'd0, 4'd0, 10'd0));
    expect_store(10'h61, 32'd2);
    expect_store(10'h60, 32'd9);
  endtask

  task automatic run_test(input int t);
    int   waited;
    logic ok;
    u_clk.hold_reset();
    for (int i = 0; i < PROG_LEN; i++)
      imem[i] = prog_tab[t][i];
    u_chk.clear_expect();
    for (int e = 0; e < n_exp_tab[t]; e++)
      u_chk.add_expect(exp_addr_tab[t][e], exp_data_tab[t][e]);
    u_clk.release_reset();
    waited = 0;
    while ((u_chk.n_seen < n_exp_tab[t]) && (waited < STORE_TIMEOUT)) begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (u_chk.n_seen < n_exp_tab[t])
      $display("timeout in test %s: stores stopped after %0d of %0d", name_tab[t],
               u_chk.n_seen, n_exp_tab[t]);
    repeat (20) @(negedge clk);   // Catch extra stores
    u_chk.report(name_tab[t], ok);
    if (ok)
      n_pass = n_pass + 1;
    else
      n_fail = n_fail + 1;
  endtask

  initial begin
    build_table();
    for (int t = 0; t < N_TESTS; t++)
      run_test(t);
    $display("%0d tests run, %0d passed, %0d failed", N_TESTS, n_pass, n_fail);
    if (n_fail == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- cpu24_core.f
verilog/cpu24_pkg.sv
verilog/cpu24_alu.sv
verilog/cpu24_decode.sv
verilog/cpu24_regfile.sv
verilog/cpu24_execute.sv
verilog/cpu24_core.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_cpu24.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_cpu24 \
  -f cpu24_core.f -o tb_cpu24 \
  && ./obj_dir/tb_cpu24 | tee /dev/stderr | grep -q "TEST PASS" \
  && echo "simulation passed" && exit 0

echo "simulation failed"
exit 1
